/* bench/program_input.txt */
# Columns: test op addr data expected (hex). Ops: issue write read werr rerr
# issue writes INSTR, werr and rerr expect PSLVERR, expected is checked on read only
reset read 00 0000 0000
reset read 04 0000 0000
reset read 08 0000 0000
reset read 0C 0000 0000
reset read 14 0000 0000
loads issue 10 4105 0000
loads issue 10 42FD 0000
loads issue 10 53F0 0000
loads issue 10 6012 0000
loads read 00 0000 1200
loads read 04 0000 0005
loads read 08 0000 FFFD
loads read 0C 0000 00F0
alu issue 10 F600 0000
alu read 00 0000 0002
alu issue 10 F701 0000
alu read 00 0000 FF15
alu issue 10 FB02 0000
alu read 00 0000 00F0
alu issue 10 F703 0000
alu read 00 0000 00F5
alu issue 10 FC04 0000
alu read 00 0000 FF0F
alu issue 10 F405 0000
alu read 00 0000 FFFB
alu issue 10 FC06 0000
alu read 00 0000 01E0
alu issue 10 F807 0000
alu read 00 0000 FFFE
alu read 14 0000 000C
memory issue 10 8710 0000
memory issue 10 7818 0000
memory read 00 0000 00F0
memory read 14 0000 000E
branch write 14 0020 0000
branch issue 10 0304 0000
branch read 14 0000 0021
branch issue 10 0104 0000
branch read 14 0000 0026
branch issue 10 13FE 0000
branch read 14 0000 0025
branch issue 10 11FE 0000
branch read 14 0000 0026
branch issue 10 2408 0000
branch read 14 0000 002F
branch issue 10 2808 0000
branch read 14 0000 0030
branch issue 10 3810 0000
branch read 14 0000 0041
branch issue 10 3410 0000
branch read 14 0000 0042
jump write 14 5123 0000
jump issue 10 9456 0000
jump read 14 0000 5456
jump issue 10 A0AB 0000
jump read 14 0000 50AB
jump read 08 0000 5457
jump issue 10 F419 0000
jump read 14 0000 0005
jump issue 10 FC1A 0000
jump read 14 0000 00F0
jump read 08 0000 0006
errors werr 00 1234 0000
errors rerr 10 0000 0000
errors rerr 20 0000 0000
errors werr 18 5555 0000
unknown issue 10 B123 0000
unknown issue 10 F43F 0000
unknown read 00 0000 00F0
unknown read 04 0000 0005
unknown read 08 0000 0006
unknown read 0C 0000 00F0
unknown read 14 0000 00F2

/* compile.f */
src/tscPkg.sv
src/registerFile.sv
src/apbIssuePort.sv
src/controlDecoder.sv
src/executeUnit.sv
src/resultStage.sv
src/tscCore.sv
bench/tscCore_assertions.sv
bench/tscCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the tscCore testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tscCoreTb -f compile.f

# The simulator status is not trusted alone, the log decides
./obj_dir/VtscCoreTb | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
	echo "Run result: pass"
	exit 0
fi
echo "Run result: fail, see sim.log"
exit 1

/* bench/tscCoreTb.sv */
`timescale 1ns/1ns
`default_nettype none

module tscCoreTb;

	localparam int period    = 8;
	localparam int maxAccess = 8;  // Access cycles allowed before PREADY counts as missing

	typedef struct packed {
		logic [7:0]  addr;
		logic [15:0] data;
		logic [15:0] expVal;
	} cmdT;

	logic        clk;
	logic        rst;
	logic        PSEL;
	logic        PENABLE;
	logic        PWRITE;
	logic [7:0]  PADDR;
	logic [15:0] PWDATA;
	logic [15:0] PRDATA;
	logic        PREADY;
	logic        PSLVERR;

	string names[$];
	string ops[$];
	cmdT   cmds[$];
	int    cmdCount;
	logic  loaded;
	int    testChecks;
	int    testErrors;
	int    totalChecks;
	int    totalErrors;
	int    testCount;

	tscCore #(.memDepthLog2(8)) UUT (
		.clk, .rst, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
		.PRDATA, .PREADY, .PSLVERR
	);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	task automatic loadCommands();
		int          fd;
		int          n;
		string       line;
		string       name;
		string       op;
		logic [7:0]  addr;
		logic [15:0] data;
		logic [15:0] expVal;
		fd = $fopen("bench/program_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open bench/program_input.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 3 || line.getc(0) == "#")
				continue;  // Blank or column comment
			n = $sscanf(line, "%s %s %h %h %h", name, op, addr, data, expVal);
			if (n == 5) begin
				names.push_back(name);
				ops.push_back(op);
				cmds.push_back(cmdT'{addr, data, expVal});
			end else begin
				$display("Command line could not be parsed: %s", line);
				totalErrors++;
			end
		end
		$fclose(fd);
		cmdCount = names.size();
	endtask

	// One APB3 transfer, sampled at the falling edge
	task automatic apbTransfer(input logic write, input logic [7:0] addr,
		input logic [15:0] data, output logic [15:0] rdata, output logic err,
		output int waits, output logic done);
		rdata = '0;
		err   = 1'b0;
		waits = 0;
		done  = 1'b0;
		@(posedge clk);
		PSEL    <= 1'b1;
		PENABLE <= 1'b0;  // Setup cycle
		PWRITE  <= write;
		PADDR   <= addr;
		PWDATA  <= data;
		@(posedge clk);
		PENABLE <= 1'b1;
		while (!done && waits < maxAccess) begin
			@(negedge clk);
			waits++;
			if (PREADY) begin
				done  = 1'b1;
				rdata = PRDATA;
				err   = PSLVERR;
			end
		end
		@(posedge clk);
		PSEL    <= 1'b0;
		PENABLE <= 1'b0;
	endtask

	task automatic checkValue(input string sig, input logic [15:0] expVal,
		input logic [15:0] actVal);
		testChecks++;
		assert (actVal === expVal) else begin
			$display("Mismatch at %0t ns: %s expected 0x%04h, got 0x%04h",
				$time, sig, expVal, actVal);
			testErrors++;
		end
	endtask

	task automatic runCommand(input string op, input cmdT cmd);
		logic [15:0] rdata;
		logic        err;
		int          waits;
		logic        done;
		logic        isWrite;
		logic        expErr;
		isWrite = (op == "issue" || op == "write" || op == "werr");
		expErr  = (op == "werr" || op == "rerr");
		if (!isWrite && op != "read" && op != "rerr") begin
			$display("Unknown operation %s in the command file", op);
			testErrors++;
			return;
		end
		apbTransfer(isWrite, cmd.addr, cmd.data, rdata, err, waits, done);
		testChecks++;
		assert (done) else begin
			$display("At %0t ns PREADY never rose within %0d access cycles (%s at 0x%02h)",
				$time, maxAccess, op, cmd.addr);
			testErrors++;
		end
		if (!done)
			return;
		checkValue("PSLVERR", {15'd0, expErr}, {15'd0, err});
		if (op == "issue")
			checkValue("PREADY latency", 16'd4, waits[15:0]);  // Decode, execute, write back
		else
			checkValue("PREADY latency", 16'd1, waits[15:0]);
		if (op == "read")
			checkValue($sformatf("PRDATA at 0x%02h", cmd.addr), cmd.expVal, rdata);
	endtask

	task automatic reportTest(input string name);
		$display("Test %-8s %0d checks, %0d errors", name, testChecks, testErrors);
		totalChecks += testChecks;
		totalErrors += testErrors;
		testCount++;
		testChecks = 0;
		testErrors = 0;
	endtask

	initial begin
		rst         = 1'b1;
		PSEL        = 1'b0;
		PENABLE     = 1'b0;
		PWRITE      = 1'b0;
		PADDR       = '0;
		PWDATA      = '0;
		loaded      = 1'b0;
		cmdCount    = 0;
		testChecks  = 0;
		testErrors  = 0;
		totalChecks = 0;
		totalErrors = 0;
		testCount   = 0;
		loadCommands();
		loaded = 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < cmdCount; i++) begin
			if (i > 0 && names[i] != names[i-1])
				reportTest(names[i-1]);  // Test name changed
			runCommand(ops[i], cmds[i]);
		end
		if (cmdCount > 0) begin
			reportTest(names[cmdCount-1]);
		end else begin
			$display("No commands were loaded");
			totalErrors++;
		end
		$display("Tests %0d, checks %0d, errors %0d", testCount, totalChecks, totalErrors);
		if (totalErrors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial begin
		wait (loaded === 1'b1);
		repeat (cmdCount * 10 + 100) @(posedge clk);
		$display("Watchdog expired after %0d cycles", cmdCount * 10 + 100);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/tscCore_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module tscCoreAssertions (
	input wire logic clk,
	input wire logic rst,
	input wire logic PSEL,
	input wire logic PENABLE,
	input wire logic PREADY,
	input wire logic PSLVERR,
	input wire logic issueValid,
	input wire logic retire
);

	readyInAccess: assert property (@(posedge clk) disable iff (rst)
		PREADY |-> PSEL && PENABLE)
		else $error("PREADY high outside an access cycle");

	errWithReady: assert property (@(posedge clk) disable iff (rst)
		PSLVERR |-> PREADY)
		else $error("PSLVERR high without PREADY");

	// INSTR write ends in its fourth access cycle
	instrWaits: assert property (@(posedge clk) disable iff (rst)
		issueValid |-> !PREADY ##1 !PREADY ##1 !PREADY ##1 PREADY)
		else $error("INSTR transfer did not wait three access cycles");

	retireAfterIssue: assert property (@(posedge clk) disable iff (rst)
		issueValid |-> ##3 retire ##1 !retire)
		else $error("No single retire pulse three cycles after issue");

	retireNeedsIssue: assert property (@(posedge clk) disable iff (rst)
		retire |-> $past(issueValid, 3))
		else $error("Retire pulse without a matching issue");

endmodule

bind tscCore tscCoreAssertions checks (
	.clk, .rst, .PSEL, .PENABLE, .PREADY, .PSLVERR, .issueValid, .retire
);

`default_nettype wire

/* src/tscCore.sv */
`timescale 1ns/1ns
`default_nettype none

module tscCore #(
	parameter int memDepthLog2 = 8
) (
	input  wire logic                         clk,
	input  wire logic                         rst,
	input  wire logic                         PSEL,
	input  wire logic                         PENABLE,
	input  wire logic                         PWRITE,
	input  wire logic [7:0]                   PADDR,
	input  wire logic [tscPkg::wordWidth-1:0] PWDATA,
	output logic      [tscPkg::wordWidth-1:0] PRDATA,
	output logic                              PREADY,
	output logic                              PSLVERR
);

	logic                           issueValid;
	logic [tscPkg::wordWidth-1:0]   issueInstr;
	tscPkg::decodedT                decoded;
	logic                           decValid;
	tscPkg::execT                   exec;
	logic                           execValid;
	logic [tscPkg::regIdxWidth-1:0] rsIdx;
	logic [tscPkg::regIdxWidth-1:0] rtIdx;
	logic [tscPkg::regIdxWidth-1:0] hostIdx;
	logic [tscPkg::wordWidth-1:0]   rsData;
	logic [tscPkg::wordWidth-1:0]   rtData;
	logic [tscPkg::wordWidth-1:0]   hostData;
	logic                           wrEn;
	logic [tscPkg::regIdxWidth-1:0] wrIdx;
	logic [tscPkg::wordWidth-1:0]   wrData;
	logic [tscPkg::wordWidth-1:0]   pc;
	logic                           pcLoad;
	logic [tscPkg::wordWidth-1:0]   pcLoadValue;
	logic                           retire;

	apbIssuePort port (
		.clk, .rst, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
		.retire, .hostData, .pc,
		.PRDATA, .PREADY, .PSLVERR,
		.issueValid, .issueInstr, .hostIdx, .pcLoad, .pcLoadValue
	);

	controlDecoder decode (
		.clk, .rst, .issueValid, .issueInstr, .decoded, .decValid
	);

	executeUnit execute (
		.clk, .rst, .decoded, .decValid, .rsData, .rtData, .pc,
		.rsIdx, .rtIdx, .exec, .execValid
	);

	resultStage #(.memDepthLog2(memDepthLog2)) writeBack (
		.clk, .rst, .exec, .execValid, .pcLoad, .pcLoadValue,
		.wrEn, .wrIdx, .wrData, .pc, .retire
	);

	registerFile regFile (
		.clk, .rst, .rsIdx, .rtIdx, .hostIdx, .wrEn, .wrIdx, .wrData,
		.rsData, .rtData, .hostData
	);

endmodule

`default_nettype wire

/* src/resultStage.sv */
`timescale 1ns/1ns
`default_nettype none

module resultStage #(
	parameter int memDepthLog2 = 8
) (
	input  wire logic                           clk,
	input  wire logic                           rst,
	input  wire tscPkg::execT                   exec,
	input  wire logic                           execValid,
	input  wire logic                           pcLoad,
	input  wire logic [tscPkg::wordWidth-1:0]   pcLoadValue,
	output logic                                wrEn,
	output logic      [tscPkg::regIdxWidth-1:0] wrIdx,
	output logic      [tscPkg::wordWidth-1:0]   wrData,
	output logic      [tscPkg::wordWidth-1:0]   pc,
	output logic                                retire
);

	logic [tscPkg::wordWidth-1:0] mem [2**memDepthLog2];
	logic [memDepthLog2-1:0]      memIdx;
	logic [tscPkg::wordWidth-1:0] memData;

	assign memIdx  = exec.aluResult[memDepthLog2-1:0];  // Wraps at memory depth
	assign memData = exec.ctrl.memRead ? mem[memIdx] : '0;

	assign wrEn  = execValid & exec.ctrl.regWrite;
	assign wrIdx = exec.destIdx;

	always_comb begin
		case (exec.ctrl.wbSel)
			tscPkg::wbMem:   wrData = memData;
			tscPkg::wbLink:  wrData = pc + 16'd1;  // PC still holds this instruction
			tscPkg::wbUpper: wrData = exec.upperImm;
			default:         wrData = exec.aluResult;
		endcase
	end

	always_ff @(posedge clk) begin
		if (execValid && exec.ctrl.memWrite)
			mem[memIdx] <= exec.storeData;
	end

	// Retiring instruction wins over a host load
	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else if (execValid)
			pc <= exec.nextPc;
		else if (pcLoad)
			pc <= pcLoadValue;
	end

	always_ff @(posedge clk) begin
		if (rst)
			retire <= 1'b0;
		else
			retire <= execValid;
	end

endmodule

`default_nettype wire

/* src/executeUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module executeUnit (
	input  wire logic                           clk,
	input  wire logic                           rst,
	input  wire tscPkg::decodedT                decoded,
	input  wire logic                           decValid,
	input  wire logic [tscPkg::wordWidth-1:0]   rsData,
	input  wire logic [tscPkg::wordWidth-1:0]   rtData,
	input  wire logic [tscPkg::wordWidth-1:0]   pc,
	output logic      [tscPkg::regIdxWidth-1:0] rsIdx,
	output logic      [tscPkg::regIdxWidth-1:0] rtIdx,
	output tscPkg::execT                        exec,
	output logic                                execValid
);

	logic [tscPkg::wordWidth-1:0]   immExt;
	logic [tscPkg::wordWidth-1:0]   opB;
	logic [tscPkg::wordWidth-1:0]   aluResult;
	logic [tscPkg::wordWidth-1:0]   pcPlus1;
	logic [tscPkg::wordWidth-1:0]   nextPc;
	logic [tscPkg::regIdxWidth-1:0] destIdx;
	logic                           taken;

	assign rsIdx = decoded.rsIdx;
	assign rtIdx = decoded.rtIdx;

	// ORI zero-extends, the rest sign-extend
	assign immExt = (decoded.opcode == tscPkg::opOri) ? {8'h00, decoded.imm}
		: {{8{decoded.imm[7]}}, decoded.imm};
	assign opB     = decoded.ctrl.useImm ? immExt : rtData;
	assign pcPlus1 = pc + 16'd1;

	always_comb begin
		case (decoded.ctrl.aluOp)
			tscPkg::aluAdd: aluResult = rsData + opB;
			tscPkg::aluSub: aluResult = rsData - opB;
			tscPkg::aluAnd: aluResult = rsData & opB;
			tscPkg::aluOr:  aluResult = rsData | opB;
			tscPkg::aluNot: aluResult = ~rsData;
			tscPkg::aluTcp: aluResult = ~rsData + 16'd1;
			tscPkg::aluShl: aluResult = rsData << 1;
			tscPkg::aluShr: aluResult = $signed(rsData) >>> 1;
			default:        aluResult = '0;
		endcase
	end

	always_comb begin
		case (decoded.opcode)
			tscPkg::opBne: taken = (rsData != rtData);
			tscPkg::opBeq: taken = (rsData == rtData);
			tscPkg::opBgz: taken = ($signed(rsData) > 0);
			tscPkg::opBlz: taken = ($signed(rsData) < 0);
			default:       taken = 1'b0;
		endcase
	end

	always_comb begin
		if (decoded.ctrl.jump && decoded.ctrl.jumpReg)
			nextPc = rsData;
		else if (decoded.ctrl.jump)
			nextPc = {pc[15:12], decoded.target};  // Keep the page bits
		else if (decoded.ctrl.branch && taken)
			nextPc = pcPlus1 + {{8{decoded.imm[7]}}, decoded.imm};
		else
			nextPc = pcPlus1;
	end

	always_comb begin
		case (decoded.ctrl.destSel)
			tscPkg::destRd: destIdx = decoded.rdIdx;
			tscPkg::destR2: destIdx = 2'd2;  // Link register
			default:        destIdx = decoded.rtIdx;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			execValid <= 1'b0;
		else
			execValid <= decValid;
	end

	always_ff @(posedge clk) begin
		if (decValid) begin
			exec.ctrl      <= decoded.ctrl;
			exec.aluResult <= aluResult;
			exec.storeData <= rtData;
			exec.destIdx   <= destIdx;
			exec.nextPc    <= nextPc;
			exec.upperImm  <= {decoded.imm, 8'h00};
		end
	end

endmodule

`default_nettype wire

/* src/controlDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module controlDecoder (
	input  wire logic                         clk,
	input  wire logic                         rst,
	input  wire logic                         issueValid,
	input  wire logic [tscPkg::wordWidth-1:0] issueInstr,
	output tscPkg::decodedT                   decoded,
	output logic                              decValid
);

	logic [tscPkg::opcodeWidth-1:0] opcode;
	logic [tscPkg::funcWidth-1:0]   func;
	tscPkg::ctrlT                   ctrl;

	assign opcode = issueInstr[15:12];
	assign func   = issueInstr[5:0];

	always_comb begin
		ctrl = '0;  // Unknown encodings do nothing
		case (opcode)
			tscPkg::opRtype: begin
				case (func)
					tscPkg::fnJpr: begin
						ctrl.jump    = 1'b1;
						ctrl.jumpReg = 1'b1;
					end
					tscPkg::fnJrl: begin
						ctrl.jump     = 1'b1;
						ctrl.jumpReg  = 1'b1;
						ctrl.regWrite = 1'b1;
						ctrl.destSel  = tscPkg::destR2;
						ctrl.wbSel    = tscPkg::wbLink;
					end
					tscPkg::fnAdd, tscPkg::fnSub, tscPkg::fnAnd, tscPkg::fnOrr,
					tscPkg::fnNot, tscPkg::fnTcp, tscPkg::fnShl, tscPkg::fnShr: begin
						ctrl.regWrite = 1'b1;
						ctrl.destSel  = tscPkg::destRd;
						ctrl.wbSel    = tscPkg::wbAlu;
						case (func)
							tscPkg::fnAdd: ctrl.aluOp = tscPkg::aluAdd;
							tscPkg::fnSub: ctrl.aluOp = tscPkg::aluSub;
							tscPkg::fnAnd: ctrl.aluOp = tscPkg::aluAnd;
							tscPkg::fnOrr: ctrl.aluOp = tscPkg::aluOr;
							tscPkg::fnNot: ctrl.aluOp = tscPkg::aluNot;
							tscPkg::fnTcp: ctrl.aluOp = tscPkg::aluTcp;
							tscPkg::fnShl: ctrl.aluOp = tscPkg::aluShl;
							default:       ctrl.aluOp = tscPkg::aluShr;
						endcase
					end
					default: ;
				endcase
			end
			tscPkg::opAdi, tscPkg::opOri: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm   = 1'b1;
				ctrl.aluOp    = (opcode == tscPkg::opAdi) ? tscPkg::aluAdd : tscPkg::aluOr;
			end
			tscPkg::opLhi: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel    = tscPkg::wbUpper;
			end
			tscPkg::opLwd: begin
				ctrl.memRead  = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel    = tscPkg::wbMem;
				ctrl.aluOp    = tscPkg::aluAdd;  // Address is rs + imm
				ctrl.useImm   = 1'b1;
			end
			tscPkg::opSwd: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluOp    = tscPkg::aluAdd;
				ctrl.useImm   = 1'b1;
			end
			tscPkg::opBne, tscPkg::opBeq, tscPkg::opBgz, tscPkg::opBlz:
				ctrl.branch = 1'b1;
			tscPkg::opJmp:
				ctrl.jump = 1'b1;
			tscPkg::opJal: begin
				ctrl.jump     = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.destSel  = tscPkg::destR2;
				ctrl.wbSel    = tscPkg::wbLink;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			decValid <= 1'b0;
		else
			decValid <= issueValid;
	end

	always_ff @(posedge clk) begin
		if (issueValid) begin
			decoded.ctrl   <= ctrl;
			decoded.opcode <= opcode;
			decoded.rsIdx  <= issueInstr[11:10];
			decoded.rtIdx  <= issueInstr[9:8];
			decoded.rdIdx  <= issueInstr[7:6];
			decoded.imm    <= issueInstr[7:0];
			decoded.target <= issueInstr[11:0];
		end
	end

endmodule

`default_nettype wire

/* src/apbIssuePort.sv */
`timescale 1ns/1ns
`default_nettype none

module apbIssuePort (
	input  wire logic                           clk,
	input  wire logic                           rst,
	input  wire logic                           PSEL,
	input  wire logic                           PENABLE,
	input  wire logic                           PWRITE,
	input  wire logic [7:0]                     PADDR,
	input  wire logic [tscPkg::wordWidth-1:0]   PWDATA,
	input  wire logic                           retire,
	input  wire logic [tscPkg::wordWidth-1:0]   hostData,
	input  wire logic [tscPkg::wordWidth-1:0]   pc,
	output logic      [tscPkg::wordWidth-1:0]   PRDATA,
	output logic                                PREADY,
	output logic                                PSLVERR,
	output logic                                issueValid,
	output logic      [tscPkg::wordWidth-1:0]   issueInstr,
	output logic      [tscPkg::regIdxWidth-1:0] hostIdx,
	output logic                                pcLoad,
	output logic      [tscPkg::wordWidth-1:0]   pcLoadValue
);

	logic busy;      // Instruction issued, waiting for retire
	logic access;
	logic isReg;
	logic isInstr;
	logic isPc;
	logic errCond;
	logic instrWrite;

	always_comb begin
		isReg   = 1'b0;
		isInstr = 1'b0;
		isPc    = 1'b0;
		case (PADDR)
			tscPkg::addrReg0, tscPkg::addrReg1,
			tscPkg::addrReg2, tscPkg::addrReg3: isReg = 1'b1;
			tscPkg::addrInstr: isInstr = 1'b1;
			tscPkg::addrPc: isPc = 1'b1;
			default: ;
		endcase
	end

	assign access     = PSEL & PENABLE;
	assign instrWrite = access & PWRITE & isInstr;
	assign errCond    = (isReg & PWRITE) | (isInstr & ~PWRITE) | ~(isReg | isInstr | isPc);

	// Issue only once per transfer, in its first access cycle
	assign issueValid = instrWrite & ~busy;
	assign issueInstr = PWDATA;

	// INSTR writes wait for retire, everything else is zero wait
	assign PREADY  = access & (~(PWRITE & isInstr) | (busy & retire));
	assign PSLVERR = PREADY & errCond;

	assign hostIdx     = PADDR[3:2];
	assign pcLoad      = access & PWRITE & isPc;
	assign pcLoadValue = PWDATA;

	always_comb begin
		if (isReg)
			PRDATA = hostData;
		else if (isPc)
			PRDATA = pc;
		else
			PRDATA = '0;
	end

	always_ff @(posedge clk) begin
		if (rst)
			busy <= 1'b0;
		else if (issueValid)
			busy <= 1'b1;
		else if (retire)
			busy <= 1'b0;
	end

endmodule

`default_nettype wire

/* src/registerFile.sv */
`timescale 1ns/1ns
`default_nettype none

module registerFile (
	input  wire logic                           clk,
	input  wire logic                           rst,
	input  wire logic [tscPkg::regIdxWidth-1:0] rsIdx,
	input  wire logic [tscPkg::regIdxWidth-1:0] rtIdx,
	input  wire logic [tscPkg::regIdxWidth-1:0] hostIdx,
	input  wire logic                           wrEn,
	input  wire logic [tscPkg::regIdxWidth-1:0] wrIdx,
	input  wire logic [tscPkg::wordWidth-1:0]   wrData,
	output logic      [tscPkg::wordWidth-1:0]   rsData,
	output logic      [tscPkg::wordWidth-1:0]   rtData,
	output logic      [tscPkg::wordWidth-1:0]   hostData
);

	localparam int numRegs = 2**tscPkg::regIdxWidth;

	logic [tscPkg::wordWidth-1:0] regs [numRegs];

	assign rsData   = regs[rsIdx];
	assign rtData   = regs[rtIdx];
	assign hostData = regs[hostIdx];  // Host view over APB

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < numRegs; i++)
				regs[i] <= '0;
		end else if (wrEn) begin
			regs[wrIdx] <= wrData;
		end
	end

endmodule

`default_nettype wire

/* src/tscPkg.sv */
`default_nettype none

package tscPkg;

	localparam int wordWidth   = 16;
	localparam int regIdxWidth = 2;
	localparam int opcodeWidth = 4;
	localparam int funcWidth   = 6;
	localparam int immWidth    = 8;
	localparam int targetWidth = 12;

	// Opcodes in the top nibble
	localparam logic [opcodeWidth-1:0] opBne   = 4'd0;
	localparam logic [opcodeWidth-1:0] opBeq   = 4'd1;
	localparam logic [opcodeWidth-1:0] opBgz   = 4'd2;
	localparam logic [opcodeWidth-1:0] opBlz   = 4'd3;
	localparam logic [opcodeWidth-1:0] opAdi   = 4'd4;
	localparam logic [opcodeWidth-1:0] opOri   = 4'd5;
	localparam logic [opcodeWidth-1:0] opLhi   = 4'd6;
	localparam logic [opcodeWidth-1:0] opLwd   = 4'd7;
	localparam logic [opcodeWidth-1:0] opSwd   = 4'd8;
	localparam logic [opcodeWidth-1:0] opJmp   = 4'd9;
	localparam logic [opcodeWidth-1:0] opJal   = 4'd10;
	localparam logic [opcodeWidth-1:0] opRtype = 4'd15;

	// R-type function field
	localparam logic [funcWidth-1:0] fnAdd = 6'd0;
	localparam logic [funcWidth-1:0] fnSub = 6'd1;
	localparam logic [funcWidth-1:0] fnAnd = 6'd2;
	localparam logic [funcWidth-1:0] fnOrr = 6'd3;
	localparam logic [funcWidth-1:0] fnNot = 6'd4;
	localparam logic [funcWidth-1:0] fnTcp = 6'd5;
	localparam logic [funcWidth-1:0] fnShl = 6'd6;
	localparam logic [funcWidth-1:0] fnShr = 6'd7;
	localparam logic [funcWidth-1:0] fnJpr = 6'd25;
	localparam logic [funcWidth-1:0] fnJrl = 6'd26;

	typedef enum logic [3:0] {
		aluZero, aluAdd, aluSub, aluAnd, aluOr, aluNot, aluTcp, aluShl, aluShr
	} aluOpT;

	typedef enum logic [1:0] {
		wbAlu, wbMem, wbLink, wbUpper
	} wbSelT;

	typedef enum logic [1:0] {
		destRt, destRd, destR2
	} destSelT;

	typedef enum logic [7:0] {
		addrReg0  = 8'h00,
		addrReg1  = 8'h04,
		addrReg2  = 8'h08,
		addrReg3  = 8'h0C,
		addrInstr = 8'h10,
		addrPc    = 8'h14
	} apbAddrT;

	typedef struct packed {
		logic    jump;
		logic    jumpReg;  // Target from rs
		logic    branch;
		logic    memRead;
		logic    memWrite;
		logic    regWrite;
		destSelT destSel;
		wbSelT   wbSel;
		aluOpT   aluOp;
		logic    useImm;   // Second operand is the extended immediate
	} ctrlT;

	typedef struct packed {
		ctrlT                   ctrl;
		logic [opcodeWidth-1:0] opcode;
		logic [regIdxWidth-1:0] rsIdx;
		logic [regIdxWidth-1:0] rtIdx;
		logic [regIdxWidth-1:0] rdIdx;
		logic [immWidth-1:0]    imm;
		logic [targetWidth-1:0] target;
	} decodedT;

	typedef struct packed {
		ctrlT                   ctrl;
		logic [wordWidth-1:0]   aluResult;
		logic [wordWidth-1:0]   storeData;
		logic [regIdxWidth-1:0] destIdx;
		logic [wordWidth-1:0]   nextPc;
		logic [wordWidth-1:0]   upperImm;
	} execT;

endpackage

`default_nettype wire
